// ==== bench/copy_checker.sv ====
// --------------------------------------------------------------------------
// Copy engine checker
// Mirrors memory writes in a shadow memory and compares every finished
// job with the preloaded source words
// --------------------------------------------------------------------------

`default_nettype none

module copy_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start,
  input  lsm_pkg::job_t             job,
  input  logic [lsm_pkg::LEN_W-1:0] exp_writes,
  input  logic                      busy,
  input  logic                      done,
  input  lsm_pkg::mem_req_t         mem_req,
  input  logic                      mem_gnt,
  output int                        mismatch_cnt,
  output int                        other_cnt,
  output int                        jobs_done
);
  import lsm_pkg::*;

  logic [DATA_W-1:0] shadow [1024];
  job_t              exp_job;
  logic [LEN_W-1:0]  exp_wr;
  logic              job_open;
  logic              was_idle;  // no job open before this edge
  logic              exp_busy;
  int                wr_cnt;
  int                rd_cnt;
  int                age;       // cycles since the job was accepted

  function automatic logic [DATA_W-1:0] preload_word(int a);
    return 32'hc0de_0000 ^ (32'(a) * 32'h9e37_79b9);
  endfunction

  task automatic report_mismatch(string sig, logic [DATA_W-1:0] exp_v,
                                 logic [DATA_W-1:0] got_v);
    $display("Mismatch at %0t: %s expected %h got %h", $time, sig, exp_v, got_v);
    mismatch_cnt++;
  endtask

  task automatic report_failure(string what);
    $display("Error at %0t: %s", $time, what);
    other_cnt++;
  endtask

  // source range is untouched by the job, so its shadow words still hold
  task automatic check_dest();
    logic [ADDR_W-1:0] s;
    logic [ADDR_W-1:0] d;
    logic [DATA_W-1:0] want;
    for (int i = 0; i < int'(exp_job.len); i++) begin
      s    = exp_job.src_addr + ADDR_W'(i);
      d    = exp_job.dst_addr + ADDR_W'(i);
      want = (exp_job.op == OP_INVERT) ? ~shadow[s] : shadow[s];
      if (shadow[d] !== want) report_mismatch($sformatf("dest word %0h", d), want, shadow[d]);
    end
  endtask

  initial begin
    for (int a = 0; a < 1024; a++) shadow[a] = preload_word(a);
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      mismatch_cnt = 0;
      other_cnt    = 0;
      jobs_done    = 0;
      job_open     = 1'b0;
      age          = 0;
    end else begin
      if (job_open) age++;
      was_idle = !job_open;
      // busy from the cycle after a nonempty start, low again with done
      exp_busy = job_open && exp_job.len != '0 && !done;
      if (busy !== exp_busy) report_mismatch("busy", 32'(exp_busy), 32'(busy));
      if (mem_req.req && (!job_open || exp_job.len == '0)) begin
        report_failure("memory request with no copy job running");
      end else if (mem_req.req && mem_gnt) begin
        if (mem_req.we) begin
          if (mem_req.addr !== exp_job.dst_addr + ADDR_W'(wr_cnt))
            report_mismatch("mem_req.addr (write)",
                            32'(exp_job.dst_addr + ADDR_W'(wr_cnt)), 32'(mem_req.addr));
          shadow[mem_req.addr] = mem_req.wdata;
          wr_cnt++;
        end else begin
          if (mem_req.addr !== exp_job.src_addr + ADDR_W'(rd_cnt))
            report_mismatch("mem_req.addr (read)",
                            32'(exp_job.src_addr + ADDR_W'(rd_cnt)), 32'(mem_req.addr));
          rd_cnt++;
        end
      end
      if (done) begin
        if (!job_open) begin
          report_failure("done pulse without an accepted job");
        end else begin
          if (exp_job.len == '0 && age != 1)
            report_failure("zero-length job did not finish one cycle after start");
          if (wr_cnt != int'(exp_wr)) report_mismatch("write count", 32'(exp_wr), 32'(wr_cnt));
          check_dest();
          job_open = 1'b0;
          jobs_done++;
        end
      end
      if (start && was_idle) begin  // engine idle, start accepted
        exp_job  = job;
        exp_wr   = exp_writes;
        job_open = 1'b1;
        wr_cnt   = 0;
        rd_cnt   = 0;
        age      = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/copy_engine_assertions.sv ====
// --------------------------------------------------------------------------
// Copy engine assertions
// Channel hold rules and read bound on the mixer, done pulse on control
// --------------------------------------------------------------------------

`default_nettype none

module copy_engine_assertions (
  input logic              clk_i,
  input logic              rst_ni,
  input lsm_pkg::mem_req_t load_req,
  input logic              load_gnt,
  input lsm_pkg::mem_req_t store_req,
  input logic              store_gnt,
  input lsm_pkg::mem_req_t mem_req,
  input logic              mem_gnt,
  input lsm_pkg::mem_rsp_t mem_rsp,
  input logic              done
);
  import lsm_pkg::*;

  int reads_open;  // granted reads still waiting for data

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reads_open <= 0;
    end else begin
      reads_open <= reads_open + int'(mem_req.req && mem_gnt && !mem_req.we)
                    - int'(mem_rsp.valid);
    end
  end

  load_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_req.req && !load_gnt |=> $stable(load_req))
    else $error("load request changed before its grant");

  store_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_req.req && !store_gnt |=> $stable(store_req))
    else $error("store request changed before its grant");

  reads_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reads_open <= BUF_DEPTH)
    else $error("more reads in flight than buffer slots");

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done |=> !done)
    else $error("done held for more than one cycle");

endmodule

bind copy_engine_top copy_engine_assertions u_assert (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .load_req  (load_req),
  .load_gnt  (load_gnt),
  .store_req (store_req),
  .store_gnt (store_gnt),
  .mem_req   (mem_req),
  .mem_gnt   (mem_gnt),
  .mem_rsp   (mem_rsp),
  .done      (done)
);

`default_nettype wire

// ==== bench/tb_copy_engine.sv ====
// --------------------------------------------------------------------------
// Copy engine testbench
// Applies a table of copy jobs to the engine, with a word memory model
// that stalls grants at random
// --------------------------------------------------------------------------

`default_nettype none

module tb_copy_engine;
  import lsm_pkg::*;

  localparam int N_JOBS    = 6;
  localparam int MEM_WORDS = 1024;

  typedef struct packed {
    job_t             job;
    logic             stray;       // second start while the job runs
    logic [LEN_W-1:0] exp_writes;
  } row_t;

  logic              clk_i;
  logic              rst_ni;
  logic              start;
  job_t              job;
  logic [LEN_W-1:0]  exp_writes;
  logic              busy;
  logic              done;
  mem_req_t          mem_req;
  logic              mem_gnt;
  mem_rsp_t          mem_rsp;
  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [31:0]       lfsr_q;
  row_t              tbl [N_JOBS];
  job_t              stray_job;
  int                mismatch_cnt;
  int                other_cnt;
  int                jobs_done;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(int a);
    return 32'hc0de_0000 ^ (32'(a) * 32'h9e37_79b9);  // unique per address
  endfunction

  function automatic job_t make_job(logic [ADDR_W-1:0] src, logic [ADDR_W-1:0] dst,
                                    logic [LEN_W-1:0] len, op_e op);
    job_t j;
    j.src_addr = src;
    j.dst_addr = dst;
    j.len      = len;
    j.op       = op;
    return j;
  endfunction

  function automatic row_t table_row(job_t j, logic stray, logic [LEN_W-1:0] exp_wr);
    row_t r;
    r.job        = j;
    r.stray      = stray;
    r.exp_writes = exp_wr;
    return r;
  endfunction

  always #4 clk_i = ~clk_i;

  copy_engine_top u_dut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start   (start),
    .job     (job),
    .busy    (busy),
    .done    (done),
    .mem_req (mem_req),
    .mem_gnt (mem_gnt),
    .mem_rsp (mem_rsp)
  );

  copy_checker u_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start        (start),
    .job          (job),
    .exp_writes   (exp_writes),
    .busy         (busy),
    .done         (done),
    .mem_req      (mem_req),
    .mem_gnt      (mem_gnt),
    .mismatch_cnt (mismatch_cnt),
    .other_cnt    (other_cnt),
    .jobs_done    (jobs_done)
  );

  // memory model, read data one cycle after the grant
  always @(posedge clk_i) begin
    lfsr_q = lfsr_step(lfsr_q);
    mem_gnt       <= lfsr_q[0];  // random grant stalls
    mem_rsp.valid <= 1'b0;
    if (mem_req.req && mem_gnt) begin
      if (mem_req.we) begin
        mem[mem_req.addr] <= mem_req.wdata;
      end else begin
        mem_rsp.valid <= 1'b1;
        mem_rsp.rdata <= mem[mem_req.addr];
      end
    end
  end

  task automatic run_job(input int i);
    @(posedge clk_i);
    start      <= 1'b1;
    job        <= tbl[i].job;
    exp_writes <= tbl[i].exp_writes;
    @(posedge clk_i);
    start <= 1'b0;
    if (tbl[i].stray) begin
      repeat (2) @(posedge clk_i);
      start <= 1'b1;  // engine is busy, must be ignored
      job   <= stray_job;
      @(posedge clk_i);
      start <= 1'b0;
    end
    @(posedge clk_i);
    while (!done) @(posedge clk_i);
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    start      = 1'b0;
    job        = '0;
    exp_writes = '0;
    mem_gnt    = 1'b0;
    mem_rsp    = '0;
    lfsr_q     = 32'hbb1b_bc92;
    for (int a = 0; a < MEM_WORDS; a++) mem[a] = fill_word(a);
    tbl[0] = table_row(make_job(10'h000, 10'h100, 8'd8, OP_COPY), 1'b0, 8'd8);
    tbl[1] = table_row(make_job(10'h020, 10'h140, 8'd13, OP_INVERT), 1'b1, 8'd13);
    tbl[2] = table_row(make_job(10'h040, 10'h180, 8'd0, OP_COPY), 1'b0, 8'd0);
    tbl[3] = table_row(make_job(10'h060, 10'h1c0, 8'd1, OP_INVERT), 1'b0, 8'd1);
    tbl[4] = table_row(make_job(10'h080, 10'h200, 8'd40, OP_COPY), 1'b0, 8'd40);
    tbl[5] = table_row(make_job(10'h300, 10'h3e0, 8'd32, OP_INVERT), 1'b0, 8'd32);
    stray_job = make_job(10'h050, 10'h380, 8'd5, OP_COPY);
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < N_JOBS; i++) run_job(i);
    repeat (4) @(posedge clk_i);
    $display("Closing: %0d mismatches, %0d other errors, %0d of %0d jobs done",
             mismatch_cnt, other_cnt, jobs_done, N_JOBS);
    if (mismatch_cnt == 0 && other_cnt == 0 && jobs_done == N_JOBS) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // limit grows with the total job length
  initial begin : watchdog
    int limit;
    limit = 200;
    @(posedge rst_ni);
    for (int i = 0; i < N_JOBS; i++) limit += 24 * (int'(tbl[i].job.len) + 4);
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the job table did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/copy_ctrl.sv ====
// --------------------------------------------------------------------------
// Copy engine control
// Accepts a job in idle, latches it, launches the load and store units
// and pulses done once the final store has been granted
// --------------------------------------------------------------------------

`default_nettype none

module copy_ctrl (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          start,
  input  lsm_pkg::job_t job,
  input  logic          store_last,
  output logic          launch,
  output lsm_pkg::job_t cur_job,
  output logic          busy,
  output logic          done
);
  import lsm_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        accept;  // start seen while idle
  logic        empty_job;

  assign accept    = start && (state_q == ST_IDLE);
  assign empty_job = (job.len == '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) state_d = empty_job ? ST_DONE : ST_RUN;
      end
      ST_RUN: begin
        if (store_last) state_d = ST_DONE;
      end
      ST_DONE: state_d = ST_IDLE;  // single done cycle
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      launch  <= 1'b0;
    end else begin
      state_q <= state_d;
      launch  <= accept && !empty_job;  // zero length skips the units
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) cur_job <= job;
  end

  assign busy = (state_q == ST_RUN);
  assign done = (state_q == ST_DONE);

endmodule

`default_nettype wire

// ==== design/copy_engine_top.sv ====
// --------------------------------------------------------------------------
// Copy engine top level
// Control, load unit, store unit and load/store mixer on one memory port
// --------------------------------------------------------------------------

`default_nettype none

module copy_engine_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start,
  input  lsm_pkg::job_t     job,
  output logic              busy,
  output logic              done,
  output lsm_pkg::mem_req_t mem_req,
  input  logic              mem_gnt,
  input  lsm_pkg::mem_rsp_t mem_rsp
);
  import lsm_pkg::*;

  logic                 launch;
  job_t                 cur_job;
  logic                 store_last;
  logic [BUF_CNT_W-1:0] buf_free;
  mem_req_t             load_req;
  logic                 load_gnt;
  mem_rsp_t             load_rsp;
  mem_req_t             store_req;
  logic                 store_gnt;

  copy_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start      (start),
    .job        (job),
    .store_last (store_last),
    .launch     (launch),
    .cur_job    (cur_job),
    .busy       (busy),
    .done       (done)
  );

  load_unit u_load (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .launch    (launch),
    .cur_job   (cur_job),
    .buf_free  (buf_free),
    .req       (load_req),
    .gnt       (load_gnt),
    .rsp_valid (load_rsp.valid)
  );

  store_unit u_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .launch     (launch),
    .cur_job    (cur_job),
    .rsp        (load_rsp),  // read data fills the buffer
    .buf_free   (buf_free),
    .req        (store_req),
    .gnt        (store_gnt),
    .store_last (store_last)
  );

  ls_mixer u_mixer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_req  (load_req),
    .load_gnt  (load_gnt),
    .load_rsp  (load_rsp),
    .store_req (store_req),
    .store_gnt (store_gnt),
    .mem_req   (mem_req),
    .mem_gnt   (mem_gnt),
    .mem_rsp   (mem_rsp)
  );

endmodule

`default_nettype wire

// ==== design/load_unit.sv ====
// --------------------------------------------------------------------------
// Load unit
// Issues the source word reads of a job, keeping reads in flight
// below the free slot count of the store buffer
// --------------------------------------------------------------------------

`default_nettype none

module load_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          launch,
  input  lsm_pkg::job_t                 cur_job,
  input  logic [lsm_pkg::BUF_CNT_W-1:0] buf_free,
  output lsm_pkg::mem_req_t             req,
  input  logic                          gnt,
  input  logic                          rsp_valid
);
  import lsm_pkg::*;

  logic                 active_q;    // reads still to issue
  logic [LEN_W-1:0]     issued_q;
  logic [BUF_CNT_W-1:0] inflight_q;  // granted, no response yet
  logic                 rd_fire;
  logic                 rd_last;

  assign rd_fire = req.req & gnt;
  assign rd_last = (issued_q == cur_job.len - LEN_W'(1));

  // request stays up until granted since buf_free and inflight_q
  // drop together when a response lands in the buffer
  always_comb begin
    req       = '0;
    req.req   = active_q && (inflight_q < buf_free);
    req.we    = 1'b0;
    req.addr  = cur_job.src_addr + ADDR_W'(issued_q);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      issued_q <= '0;
    end else if (launch) begin
      active_q <= 1'b1;
      issued_q <= '0;
    end else if (rd_fire) begin
      issued_q <= issued_q + LEN_W'(1);
      if (rd_last) active_q <= 1'b0;  // final read granted
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else begin
      case ({rd_fire, rsp_valid})
        2'b10:   inflight_q <= inflight_q + BUF_CNT_W'(1);
        2'b01:   inflight_q <= inflight_q - BUF_CNT_W'(1);
        default: inflight_q <= inflight_q;  // none or both
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/ls_mixer.sv ====
// --------------------------------------------------------------------------
// Load/store mixer
// Round-robin merge of the load and store request channels onto one
// memory port, with read responses steered back to the load side
// --------------------------------------------------------------------------

`default_nettype none

module ls_mixer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lsm_pkg::mem_req_t load_req,
  output logic              load_gnt,
  output lsm_pkg::mem_rsp_t load_rsp,
  input  lsm_pkg::mem_req_t store_req,
  output logic              store_gnt,
  output lsm_pkg::mem_req_t mem_req,
  input  logic              mem_gnt,
  input  lsm_pkg::mem_rsp_t mem_rsp
);
  import lsm_pkg::*;

  logic prio_store_q;  // 1 when the store channel holds priority
  logic store_wins;
  logic ptr_adv;

  // pointed channel wins when it requests, else whoever requests
  always_comb begin
    if (load_req.req && store_req.req) begin
      store_wins = prio_store_q;
    end else begin
      store_wins = store_req.req;
    end
  end

  assign ptr_adv = mem_req.req & mem_gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_store_q <= 1'b0;
    end else if (ptr_adv) begin
      prio_store_q <= ~prio_store_q;  // rotate on every transfer
    end
  end

  // forward the winner, request bit is the or of both channels
  always_comb begin
    mem_req     = store_wins ? store_req : load_req;
    mem_req.req = load_req.req | store_req.req;
  end

  // grant only reaches the current winner
  assign load_gnt  = mem_gnt & ~store_wins;
  assign store_gnt = mem_gnt &  store_wins;

  // writes get no response, so anything valid belongs to a load
  always_comb begin
    load_rsp = '0;
    if (mem_rsp.valid) begin
      load_rsp = mem_rsp;
    end
  end

endmodule

`default_nettype wire

// ==== design/lsm_pkg.sv ====
// --------------------------------------------------------------------------
// Load/store copy engine package
// Sizes, opcode and state encodings, and the job and memory channel
// structs used by the copy engine blocks
// --------------------------------------------------------------------------

`default_nettype none

package lsm_pkg;

  localparam int unsigned ADDR_W    = 10;  // word address
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned LEN_W     = 8;   // job length in words
  localparam int unsigned BUF_DEPTH = 4;   // store buffer words
  localparam int unsigned BUF_CNT_W = 3;   // holds 0..BUF_DEPTH
  localparam int unsigned BUF_PTR_W = $clog2(BUF_DEPTH);

  typedef enum logic [0:0] {
    OP_COPY   = 1'b0,  // word written unchanged
    OP_INVERT = 1'b1   // bitwise complement written
  } op_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } ctrl_state_e;

  // one copy job, 29 bits
  typedef struct packed {
    logic [ADDR_W-1:0] src_addr;
    logic [ADDR_W-1:0] dst_addr;
    logic [LEN_W-1:0]  len;
    op_e               op;
  } job_t;

  typedef struct packed {
    logic              req;
    logic              we;     // 1 for write, 0 for read
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  // read data comes back one cycle after the grant
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== design/store_unit.sv ====
// --------------------------------------------------------------------------
// Store unit
// Buffers read data in a small FIFO, applies the job opcode to the
// head word and writes it to the destination range in order
// --------------------------------------------------------------------------

`default_nettype none

module store_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          launch,
  input  lsm_pkg::job_t                 cur_job,
  input  lsm_pkg::mem_rsp_t             rsp,
  output logic [lsm_pkg::BUF_CNT_W-1:0] buf_free,
  output lsm_pkg::mem_req_t             req,
  input  logic                          gnt,
  output logic                          store_last
);
  import lsm_pkg::*;

  logic [DATA_W-1:0]    buf_mem [BUF_DEPTH];
  logic [BUF_PTR_W-1:0] wr_ptr_q;
  logic [BUF_PTR_W-1:0] rd_ptr_q;
  logic [BUF_CNT_W-1:0] count_q;
  logic [LEN_W-1:0]     idx_q;     // next destination offset
  logic                 push;
  logic                 pop;
  logic [DATA_W-1:0]    head;

  assign push       = rsp.valid;
  assign pop        = req.req & gnt;
  assign head       = buf_mem[rd_ptr_q];
  assign buf_free   = BUF_CNT_W'(BUF_DEPTH) - count_q;
  assign store_last = pop && (idx_q == cur_job.len - LEN_W'(1));

  always_comb begin
    req       = '0;
    req.req   = (count_q != '0);
    req.we    = 1'b1;
    req.addr  = cur_job.dst_addr + ADDR_W'(idx_q);
    req.wdata = (cur_job.op == OP_INVERT) ? ~head : head;
  end

  always_ff @(posedge clk_i) begin
    if (push) buf_mem[wr_ptr_q] <= rsp.rdata;
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + BUF_PTR_W'(1);
      if (pop)  rd_ptr_q <= rd_ptr_q + BUF_PTR_W'(1);
      if (push && !pop)      count_q <= count_q + BUF_CNT_W'(1);
      else if (pop && !push) count_q <= count_q - BUF_CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (launch) begin
      idx_q <= '0;
    end else if (pop) begin
      idx_q <= idx_q + LEN_W'(1);
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the copy engine testbench with Verilator, verdict from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_copy_engine -o sim_copy \
  && ./obj_dir/sim_copy > sim.log 2>&1 \
  || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src.f ====
design/lsm_pkg.sv
design/load_unit.sv
design/store_unit.sv
design/ls_mixer.sv
design/copy_ctrl.sv
design/copy_engine_top.sv
bench/copy_checker.sv
bench/copy_engine_assertions.sv
bench/tb_copy_engine.sv
